//--- Bender.yml
package:
  name: commit_stage

sources:
  - commit_pkg.sv
  - commit_if.sv
  - elastic_buffer.sv
  - gather_unit.sv
  - commit_stage.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - commit_stage_properties.sv
      - commit_stage_tb.sv

//--- build.f
commit_pkg.sv
commit_if.sv
elastic_buffer.sv
gather_unit.sv
commit_stage.sv
tb_clock_gen.sv
commit_stage_properties.sv
commit_stage_tb.sv

//--- commit_if.sv
`timescale 1ns/10ps

interface commit_if;
    import commit_pkg::*;

    logic       valid;
    logic       ready;
    commit_in_t pkt;

    // The execute side owns valid and the packet
    modport sender (
        output valid,
        output pkt,
        input  ready
    );

    // The gather side answers with ready
    modport receiver (
        input  valid,
        input  pkt,
        output ready
    );

endinterface

//--- commit_pkg.sv
package commit_pkg;

    // Core-wide dimensions
    localparam int issue_width = 4;
    localparam int issue_idx_w = 2;
    localparam int xlen        = 32;
    localparam int uuid_w      = 8;
    localparam int nw_w        = 4;
    localparam int nr_bits     = 5;

    // Lane and thread counts that fix the packet layouts below
    localparam int def_num_lanes  = 4;
    localparam int def_thread_cnt = 8;

    // Number of lane groups per warp decides how many pid bits are needed
    localparam int pid_bits = $clog2(def_thread_cnt / def_num_lanes);
    localparam int pid_w    = (pid_bits > 0) ? pid_bits : 1;

    // Packet as it leaves an execute block, one lane group wide
    typedef struct packed {
        logic [uuid_w-1:0]                    uuid;
        logic [nw_w-1:0]                      wid;
        logic [def_num_lanes-1:0]             tmask;
        logic [xlen-1:0]                      pc;
        logic                                 wb;
        logic [nr_bits-1:0]                   rd;
        logic [def_num_lanes-1:0][xlen-1:0]   data;
        logic [pid_w-1:0]                     pid;
        logic                                 sop;
        logic                                 eop;
    } commit_in_t;

    // Packet after widening to the full warp, no pid left
    typedef struct packed {
        logic [uuid_w-1:0]                    uuid;
        logic [nw_w-1:0]                      wid;
        logic [def_thread_cnt-1:0]            tmask;
        logic [xlen-1:0]                      pc;
        logic                                 wb;
        logic [nr_bits-1:0]                   rd;
        logic [def_thread_cnt-1:0][xlen-1:0]  data;
        logic                                 sop;
        logic                                 eop;
    } commit_out_t;

endpackage

//--- commit_stage.sv
`timescale 1ns/10ps

module commit_stage #(
    parameter int num_lanes  = 4,
    parameter int thread_cnt = 8,
    parameter int block_size = 2,
    parameter int out_reg    = 1
) (
    input  logic                                                       clk,
    input  logic                                                       rst_n,

    // Execute side, one entry per input port
    input  logic [block_size-1:0]                                      in_valid,
    output logic [block_size-1:0]                                      in_ready,
    input  logic [block_size-1:0][commit_pkg::uuid_w-1:0]              in_uuid,
    input  logic [block_size-1:0][commit_pkg::nw_w-1:0]                in_wid,
    input  logic [block_size-1:0][num_lanes-1:0]                       in_tmask,
    input  logic [block_size-1:0][commit_pkg::xlen-1:0]                in_pc,
    input  logic [block_size-1:0]                                      in_wb,
    input  logic [block_size-1:0][commit_pkg::nr_bits-1:0]             in_rd,
    input  logic [block_size-1:0][num_lanes-1:0][commit_pkg::xlen-1:0] in_data,
    input  logic [block_size-1:0][commit_pkg::pid_w-1:0]               in_pid,
    input  logic [block_size-1:0]                                      in_sop,
    input  logic [block_size-1:0]                                      in_eop,

    // Issue side, one entry per slot
    output logic [commit_pkg::issue_width-1:0]                         out_valid,
    input  logic [commit_pkg::issue_width-1:0]                         out_ready,
    output logic [commit_pkg::issue_width-1:0][commit_pkg::uuid_w-1:0] out_uuid,
    output logic [commit_pkg::issue_width-1:0][commit_pkg::nw_w-1:0]   out_wid,
    output logic [commit_pkg::issue_width-1:0][thread_cnt-1:0]         out_tmask,
    output logic [commit_pkg::issue_width-1:0][commit_pkg::xlen-1:0]   out_pc,
    output logic [commit_pkg::issue_width-1:0]                         out_wb,
    output logic [commit_pkg::issue_width-1:0][commit_pkg::nr_bits-1:0] out_rd,
    output logic [commit_pkg::issue_width-1:0][thread_cnt-1:0][commit_pkg::xlen-1:0] out_data,
    output logic [commit_pkg::issue_width-1:0]                         out_sop,
    output logic [commit_pkg::issue_width-1:0]                         out_eop
);
    import commit_pkg::*;

    commit_out_t out_pkt [issue_width];

    commit_if in_if [block_size] ();

    // Bundle the flat input fields into one packet per port
    for (genvar i = 0; i < block_size; i++) begin : g_pack
        assign in_if[i].valid = in_valid[i];
        assign in_if[i].pkt   = '{
            uuid:  in_uuid[i],
            wid:   in_wid[i],
            tmask: in_tmask[i],
            pc:    in_pc[i],
            wb:    in_wb[i],
            rd:    in_rd[i],
            data:  in_data[i],
            pid:   in_pid[i],
            sop:   in_sop[i],
            eop:   in_eop[i]
        };
        assign in_ready[i] = in_if[i].ready;
    end

    gather_unit #(
        .block_size (block_size),
        .num_lanes  (num_lanes),
        .thread_cnt (thread_cnt),
        .out_reg    (out_reg)
    ) u_gather (
        .clk       (clk),
        .rst_n     (rst_n),
        .commit_in (in_if),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    // Split each widened packet back onto the flat slot outputs
    for (genvar s = 0; s < issue_width; s++) begin : g_unpack
        assign out_uuid[s]  = out_pkt[s].uuid;
        assign out_wid[s]   = out_pkt[s].wid;
        assign out_tmask[s] = out_pkt[s].tmask;
        assign out_pc[s]    = out_pkt[s].pc;
        assign out_wb[s]    = out_pkt[s].wb;
        assign out_rd[s]    = out_pkt[s].rd;
        assign out_data[s]  = out_pkt[s].data;
        assign out_sop[s]   = out_pkt[s].sop;
        assign out_eop[s]   = out_pkt[s].eop;
    end

endmodule

//--- commit_stage_properties.sv
`timescale 1ns/10ps

module commit_stage_properties #(
    parameter int block_size = 2,
    parameter int thread_cnt = 8
) (
    input logic                                                        clk,
    input logic                                                        rst_n,
    input logic [block_size-1:0]                                       in_valid,
    input logic [block_size-1:0]                                       in_ready,
    input logic [block_size-1:0][commit_pkg::nw_w-1:0]                 in_wid,
    input logic [commit_pkg::issue_width-1:0]                          out_valid,
    input logic [commit_pkg::issue_width-1:0]                          out_ready,
    input logic [commit_pkg::issue_width-1:0][commit_pkg::uuid_w-1:0]  out_uuid,
    input logic [commit_pkg::issue_width-1:0][thread_cnt-1:0]          out_tmask,
    input logic [commit_pkg::issue_width-1:0][thread_cnt-1:0][commit_pkg::xlen-1:0] out_data
);
    import commit_pkg::*;

    int unsigned fail_cnt = 0;

    // A stalled slot keeps its packet until the receiver takes it
    for (genvar s = 0; s < issue_width; s++) begin : g_hold
        assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[s] && !out_ready[s] |=> out_valid[s] && $stable(out_uuid[s])
                && $stable(out_tmask[s]) && $stable(out_data[s]))
        else begin
            fail_cnt++;
            $error("slot %0d changed its packet while stalled", s);
        end
    end

    assert property (@(posedge clk) $rose(rst_n) |-> out_valid == '0)
    else begin
        fail_cnt++;
        $error("an output is valid right after reset");
    end

    // Warp id bit 1 sits above the port index in the slot number
    for (genvar i = 0; i < block_size; i++) begin : g_route
        for (genvar s = 0; s < issue_width; s++) begin : g_slot
            assert property (@(posedge clk) disable iff (!rst_n)
                in_valid[i] && in_ready[i] && ({in_wid[i][1], 1'(i)} == issue_idx_w'(s))
                    |-> ##[1:3] out_valid[s])
            else begin
                fail_cnt++;
                $error("packet from port %0d never showed up on slot %0d", i, s);
            end
        end
    end

endmodule

bind commit_stage commit_stage_properties #(
    .block_size (block_size),
    .thread_cnt (thread_cnt)
) i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_wid    (in_wid),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_uuid  (out_uuid),
    .out_tmask (out_tmask),
    .out_data  (out_data)
);

//--- commit_stage_tb.sv
`timescale 1ns/10ps

module commit_stage_tb;
    import commit_pkg::*;

    localparam int num_lanes  = 4;
    localparam int thread_cnt = 8;
    localparam int block_size = 2;
    localparam int max_tests  = 32;
    localparam int timeout    = 50;

    // One record per line of the stimulus file
    typedef struct {
        string                  name;
        int                     step;
        int                     port;
        logic [uuid_w-1:0]      uuid;
        logic [nw_w-1:0]        wid;
        logic [num_lanes-1:0]   tmask;
        logic [xlen-1:0]        pc;
        logic                   wb;
        logic [nr_bits-1:0]     rd;
        logic [xlen-1:0]        data;
        logic [pid_w-1:0]       pid;
        logic                   sop;
        logic                   eop;
        int                     stall;
        logic                   blk;
        logic [issue_idx_w-1:0] slot;
        logic [thread_cnt-1:0]  mask;
    } test_t;

    logic                                             clk;
    logic                                             rst_n;
    logic [block_size-1:0]                            in_valid;
    logic [block_size-1:0]                            in_ready;
    logic [block_size-1:0][uuid_w-1:0]                in_uuid;
    logic [block_size-1:0][nw_w-1:0]                  in_wid;
    logic [block_size-1:0][num_lanes-1:0]             in_tmask;
    logic [block_size-1:0][xlen-1:0]                  in_pc;
    logic [block_size-1:0]                            in_wb;
    logic [block_size-1:0][nr_bits-1:0]               in_rd;
    logic [block_size-1:0][num_lanes-1:0][xlen-1:0]   in_data;
    logic [block_size-1:0][pid_w-1:0]                 in_pid;
    logic [block_size-1:0]                            in_sop;
    logic [block_size-1:0]                            in_eop;
    logic [issue_width-1:0]                           out_valid;
    logic [issue_width-1:0]                           out_ready;
    logic [issue_width-1:0][uuid_w-1:0]               out_uuid;
    logic [issue_width-1:0][nw_w-1:0]                 out_wid;
    logic [issue_width-1:0][thread_cnt-1:0]           out_tmask;
    logic [issue_width-1:0][xlen-1:0]                 out_pc;
    logic [issue_width-1:0]                           out_wb;
    logic [issue_width-1:0][nr_bits-1:0]              out_rd;
    logic [issue_width-1:0][thread_cnt-1:0][xlen-1:0] out_data;
    logic [issue_width-1:0]                           out_sop;
    logic [issue_width-1:0]                           out_eop;

    test_t tests [max_tests];
    logic  seen [max_tests];
    logic  taken [max_tests];
    int    num_tests;
    int    done_cnt;
    int    last_idx [issue_width];
    int    stall_cnt [issue_width];

    tb_clock_gen #(
        .period_ns    (20),
        .reset_cycles (2)
    ) i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    commit_stage #(
        .num_lanes  (num_lanes),
        .thread_cnt (thread_cnt),
        .block_size (block_size),
        .out_reg    (1)
    ) i_commit_stage (.*);

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_slot(input string name, input logic [issue_idx_w-1:0] exp,
                              input logic [issue_idx_w-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("error %s: expected slot %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_mask(input string name, input logic [thread_cnt-1:0] exp,
                              input logic [thread_cnt-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("error %s: expected mask %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_packet(input string name, input commit_out_t exp, input commit_out_t act);
        // Threads outside the mask carry no data worth comparing
        for (int t = 0; t < thread_cnt; t++) begin
            if (!exp.tmask[t]) begin
                exp.data[t] = '0;
                act.data[t] = '0;
            end
        end
        if (act !== exp) begin
            stop_with_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // Lane j of lane group pid belongs to thread pid*num_lanes+j
    function automatic commit_out_t expected_packet(input test_t rec);
        commit_out_t p;
        p      = '0;
        p.uuid = rec.uuid;
        p.wid  = rec.wid;
        p.pc   = rec.pc;
        p.wb   = rec.wb;
        p.rd   = rec.rd;
        p.sop  = rec.sop;
        p.eop  = rec.eop;
        for (int j = 0; j < num_lanes; j++) begin
            p.tmask[rec.pid * num_lanes + j] = rec.tmask[j];
            p.data[rec.pid * num_lanes + j]  = rec.data + xlen'(j);
        end
        return p;
    endfunction

    task automatic read_tests();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("commit_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open commit_tests.txt");
        end
        num_tests = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                if (num_tests == max_tests) begin
                    stop_with_failure("commit_tests.txt holds more records than the table");
                end
                cnt = $sscanf(line, "%s %d %d %h %h %b %h %d %d %h %d %d %d %d %d %d %b",
                    tests[num_tests].name, tests[num_tests].step, tests[num_tests].port,
                    tests[num_tests].uuid, tests[num_tests].wid, tests[num_tests].tmask,
                    tests[num_tests].pc, tests[num_tests].wb, tests[num_tests].rd,
                    tests[num_tests].data, tests[num_tests].pid, tests[num_tests].sop,
                    tests[num_tests].eop, tests[num_tests].stall, tests[num_tests].blk,
                    tests[num_tests].slot, tests[num_tests].mask);
                if (cnt != 17) begin
                    stop_with_failure($sformatf("malformed record in commit_tests.txt: %s", line));
                end
                seen[num_tests]  = 1'b0;
                taken[num_tests] = 1'b0;
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    // Match every packet that the issue side takes to its record by uuid
    task automatic collect_outputs();
        commit_out_t act;
        int          idx;
        // An accepted packet must sit on its slot's output from the next cycle on
        for (int k = 0; k < num_tests; k++) begin
            if (taken[k] && !seen[k] && !out_valid[tests[k].slot]) begin
                stop_with_failure($sformatf("slot %0d is idle while packet %s waits in it",
                                            tests[k].slot, tests[k].name));
            end
        end
        for (int s = 0; s < issue_width; s++) begin
            if (out_valid[s] && out_ready[s]) begin
                act = '{uuid: out_uuid[s], wid: out_wid[s], tmask: out_tmask[s], pc: out_pc[s],
                        wb: out_wb[s], rd: out_rd[s], data: out_data[s], sop: out_sop[s],
                        eop: out_eop[s]};
                idx = -1;
                for (int k = 0; k < num_tests; k++) begin
                    if (!seen[k] && tests[k].uuid == out_uuid[s]) begin
                        idx = k;
                    end
                end
                if (idx < 0) begin
                    stop_with_failure($sformatf("slot %0d sent a packet with unknown uuid %h",
                                                s, out_uuid[s]));
                end
                if (idx < last_idx[s]) begin
                    stop_with_failure($sformatf("packets left slot %0d out of order", s));
                end
                check_slot(tests[idx].name, tests[idx].slot, issue_idx_w'(s));
                check_mask(tests[idx].name, tests[idx].mask, act.tmask);
                check_packet(tests[idx].name, expected_packet(tests[idx]), act);
                seen[idx]   = 1'b1;
                last_idx[s] = idx;
                done_cnt++;
            end
        end
    endtask

    // Set out_ready for the coming rising edge and take whatever transfers on it
    task automatic next_cycle();
        @(negedge clk);
        for (int s = 0; s < issue_width; s++) begin
            out_ready[s] = (stall_cnt[s] == 0);
            if (stall_cnt[s] > 0) begin
                stall_cnt[s]--;
            end
        end
        collect_outputs();
    endtask

    task automatic drive_packet(input test_t rec);
        in_valid[rec.port] = 1'b1;
        in_uuid[rec.port]  = rec.uuid;
        in_wid[rec.port]   = rec.wid;
        in_tmask[rec.port] = rec.tmask;
        in_pc[rec.port]    = rec.pc;
        in_wb[rec.port]    = rec.wb;
        in_rd[rec.port]    = rec.rd;
        in_pid[rec.port]   = rec.pid;
        in_sop[rec.port]   = rec.sop;
        in_eop[rec.port]   = rec.eop;
        for (int j = 0; j < num_lanes; j++) begin
            in_data[rec.port][j] = rec.data + xlen'(j);
        end
        // The stall starts with the next cycle on the packet's slot
        if (rec.stall > 0) begin
            stall_cnt[rec.slot] = rec.stall;
        end
    endtask

    initial begin
        int                    k;
        int                    first;
        int                    wait_cnt;
        logic [block_size-1:0] accepted;
        in_valid  = '0;
        in_uuid   = '0;
        in_wid    = '0;
        in_tmask  = '0;
        in_pc     = '0;
        in_wb     = '0;
        in_rd     = '0;
        in_data   = '0;
        in_pid    = '0;
        in_sop    = '0;
        in_eop    = '0;
        out_ready = '1;
        done_cnt  = 0;
        for (int s = 0; s < issue_width; s++) begin
            stall_cnt[s] = 0;
            last_idx[s]  = -1;
        end
        read_tests();

        wait_cnt = 0;
        while (rst_n !== 1'b1) begin
            next_cycle();
            wait_cnt++;
            if (wait_cnt > timeout) begin
                stop_with_failure("reset was never released");
            end
        end
        next_cycle();
        if (out_valid !== '0 || in_ready !== '1) begin
            stop_with_failure("after reset an output is valid or an input is not ready");
        end

        // Records that share a step number go out in the same cycle
        k = 0;
        while (k < num_tests) begin
            first = k;
            while (k < num_tests && tests[k].step == tests[first].step) begin
                drive_packet(tests[k]);
                k++;
            end
            #1;
            for (int m = first; m < k; m++) begin
                if (in_ready[tests[m].port] !== !tests[m].blk) begin
                    stop_with_failure($sformatf("error %s: expected in_ready %b, actual %b",
                        tests[m].name, !tests[m].blk, in_ready[tests[m].port]));
                end
            end
            wait_cnt = 0;
            while (in_valid != '0) begin
                accepted = in_valid & in_ready;
                for (int m = first; m < k; m++) begin
                    if (accepted[tests[m].port]) begin
                        taken[m] = 1'b1;
                    end
                end
                next_cycle();
                in_valid = in_valid & ~accepted;
                wait_cnt++;
                if (wait_cnt > timeout) begin
                    stop_with_failure($sformatf("in_ready stayed low for step %0d",
                                                tests[first].step));
                end
            end
        end

        wait_cnt = 0;
        while (done_cnt < num_tests) begin
            next_cycle();
            wait_cnt++;
            if (wait_cnt > timeout) begin
                stop_with_failure("not every packet reached an output");
            end
        end

        if (i_commit_stage.i_props.fail_cnt != 0) begin
            stop_with_failure("the bound assertions reported failures");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- commit_tests.txt
# name step port uuid wid tmask pc wb rd data pid sop eop stall blk slot mask
# uuid wid pc data in hex, tmask and mask in binary with lane 0 rightmost, the rest decimal
steer_w0 1 0 01 0 1111 00001000 1 1 a0000000 0 1 1 0 0 0 00001111
steer_w1 2 1 02 1 1010 00001004 0 2 a1000010 1 1 0 0 0 1 10100000
steer_w2 3 0 03 2 0101 00001008 1 3 a2000020 0 0 1 0 0 2 00000101
steer_w3 4 1 04 3 1100 0000100c 1 4 a3000030 1 0 0 0 0 3 11000000
steer_w4 5 0 05 4 0011 00001010 0 5 a4000040 1 1 1 0 0 0 00110000
steer_w5 6 1 06 5 1001 00001014 1 6 a5000050 0 1 1 0 0 1 00001001
steer_w6 7 0 07 6 1110 00001018 1 7 a6000060 1 0 0 0 0 2 11100000
steer_w7 8 1 08 7 0111 0000101c 0 8 a7000070 0 1 0 0 0 3 00000111
steer_w8 9 0 09 8 1111 00001020 1 9 a8000080 1 0 1 0 0 0 11110000
steer_w9 10 1 0a 9 0001 00001024 1 10 a9000090 0 1 1 0 0 1 00000001
steer_wa 11 0 0b a 1000 00001028 0 11 aa0000a0 0 0 0 0 0 2 00001000
steer_wb 12 1 0c b 0110 0000102c 1 12 ab0000b0 1 1 1 0 0 3 01100000
steer_wc 13 0 0d c 1011 00001030 1 13 ac0000c0 0 1 0 0 0 0 00001011
steer_wd 14 1 0e d 1101 00001034 0 14 ad0000d0 1 0 1 0 0 1 11010000
steer_we 15 0 0f e 0010 00001038 1 15 ae0000e0 1 1 1 0 0 2 00100000
steer_wf 16 1 10 f 1111 0000103c 1 31 af0000f0 0 0 1 0 0 3 00001111
stall_a 17 0 11 2 1111 00002000 1 20 b0000000 0 1 0 6 0 2 00001111
stall_b 18 0 12 2 0101 00002004 1 21 b1000000 1 0 0 0 0 2 01010000
stall_c 19 0 13 2 1010 00002008 1 22 b2000000 0 0 1 0 1 2 00001010
pair_p0 20 0 14 4 1111 00003000 1 23 c0000000 0 1 1 0 0 0 00001111
pair_p1 20 1 15 5 0110 00003004 0 24 c1000000 1 1 1 0 0 1 01100000
burst_p0a 21 0 16 8 1010 00003008 1 25 c2000000 1 1 1 0 0 0 10100000
burst_p1a 21 1 17 7 0011 0000300c 1 26 c3000000 0 1 1 0 0 3 00000011
burst_p0b 22 0 18 c 0101 00003010 1 27 c4000000 0 1 1 0 0 0 00000101

//--- elastic_buffer.sv
`timescale 1ns/10ps

module elastic_buffer #(
    parameter int out_reg = 1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_in,
    output logic                   ready_in,
    input  commit_pkg::commit_in_t data_in,
    output logic                   valid_out,
    input  logic                   ready_out,
    output commit_pkg::commit_in_t data_out
);
    import commit_pkg::*;

    if (out_reg == 0) begin : g_bypass
        // No storage, the slot sees the sender directly
        assign valid_out = valid_in;
        assign data_out  = data_in;
        assign ready_in  = ready_out;
    end else begin : g_skid
        logic       main_valid;
        logic       spare_valid;
        commit_in_t main_data;
        commit_in_t spare_data;
        logic       main_load;
        logic       push;
        logic       spare_load;

        // Main register may take a new packet when empty or draining this cycle
        assign main_load  = !main_valid || ready_out;
        assign push       = valid_in && !spare_valid;
        // A packet that arrives while main is stuck parks in the spare register
        assign spare_load = push && !main_load;

        // Ready comes straight from a flop so the upstream path stays short
        assign ready_in  = !spare_valid;
        assign valid_out = main_valid;
        assign data_out  = main_data;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                main_valid  <= 1'b0;
                spare_valid <= 1'b0;
            end else begin
                if (main_load) begin
                    main_valid <= spare_valid || push;
                end
                if (spare_load) begin
                    spare_valid <= 1'b1;
                end else if (main_load) begin
                    spare_valid <= 1'b0;
                end
            end
        end

        // The parked packet is older, so it goes to main first
        always_ff @(posedge clk) begin
            if (main_load) begin
                main_data <= spare_valid ? spare_data : data_in;
            end
            if (spare_load) begin
                spare_data <= data_in;
            end
        end
    end

endmodule

//--- gather_unit.sv
`timescale 1ns/10ps

module gather_unit #(
    parameter int block_size = 1,
    parameter int num_lanes  = 4,
    parameter int thread_cnt = 8,
    parameter int out_reg    = 0
) (
    input  logic                                 clk,
    input  logic                                 rst_n,

    commit_if.receiver                           commit_in [block_size],

    output logic [commit_pkg::issue_width-1:0]   out_valid,
    input  logic [commit_pkg::issue_width-1:0]   out_ready,
    output commit_pkg::commit_out_t              out_pkt [commit_pkg::issue_width]
);
    import commit_pkg::*;

    localparam int block_size_w = (block_size > 1) ? $clog2(block_size) : 1;
    localparam int pid_sel_w    = $clog2(thread_cnt / num_lanes);

    logic       [block_size-1:0]                  in_valid;
    commit_in_t                                   in_pkt [block_size];
    logic       [block_size-1:0][issue_idx_w-1:0] in_slot;

    logic       [issue_width-1:0]                 slot_valid;
    commit_in_t                                   slot_pkt [issue_width];
    logic       [issue_width-1:0]                 slot_ready;

    logic       [issue_width-1:0]                 buf_valid;
    commit_in_t                                   buf_pkt [issue_width];

    // Work out which issue slot owns each incoming packet
    for (genvar i = 0; i < block_size; i++) begin : g_in
        assign in_valid[i] = commit_in[i].valid;
        assign in_pkt[i]   = commit_in[i].pkt;

        if (block_size == issue_width) begin : g_direct
            assign in_slot[i] = issue_idx_w'(i);
        end else if (block_size == 1) begin : g_by_wid
            assign in_slot[i] = in_pkt[i].wid[issue_idx_w-1:0];
        end else begin : g_mixed
            // Port index fills the low bits and the warp id supplies the rest
            assign in_slot[i] = {
                in_pkt[i].wid[block_size_w +: (issue_idx_w - block_size_w)],
                block_size_w'(i)
            };
        end

        // Each sender waits on whichever buffer its packet is headed for
        assign commit_in[i].ready = slot_ready[in_slot[i]];
    end

    // Crossbar from input ports onto slot buffers
    always_comb begin
        slot_valid = '0;
        for (int s = 0; s < issue_width; s++) begin
            slot_pkt[s] = '0;
        end
        for (int i = 0; i < block_size; i++) begin
            slot_valid[in_slot[i]] = in_valid[i];
            slot_pkt[in_slot[i]]   = in_pkt[i];
        end
    end

    for (genvar s = 0; s < issue_width; s++) begin : g_slot
        logic [thread_cnt-1:0]           wide_tmask;
        logic [thread_cnt-1:0][xlen-1:0] wide_data;

        elastic_buffer #(
            .out_reg (out_reg)
        ) u_buf (
            .clk       (clk),
            .rst_n     (rst_n),
            .valid_in  (slot_valid[s]),
            .ready_in  (slot_ready[s]),
            .data_in   (slot_pkt[s]),
            .valid_out (buf_valid[s]),
            .ready_out (out_ready[s]),
            .data_out  (buf_pkt[s])
        );

        if (pid_sel_w != 0) begin : g_widen
            // Lane j of group pid lands on thread pid*num_lanes+j
            always_comb begin
                wide_tmask = '0;
                wide_data  = '0;
                for (int j = 0; j < num_lanes; j++) begin
                    wide_tmask[buf_pkt[s].pid * num_lanes + j] = buf_pkt[s].tmask[j];
                    wide_data[buf_pkt[s].pid * num_lanes + j]  = buf_pkt[s].data[j];
                end
            end
        end else begin : g_copy
            // One lane group already covers the whole warp
            assign wide_tmask = buf_pkt[s].tmask;
            assign wide_data  = buf_pkt[s].data;
        end

        assign out_valid[s] = buf_valid[s];
        assign out_pkt[s]   = '{
            uuid:  buf_pkt[s].uuid,
            wid:   buf_pkt[s].wid,
            tmask: wide_tmask,
            pc:    buf_pkt[s].pc,
            wb:    buf_pkt[s].wb,
            rd:    buf_pkt[s].rd,
            data:  wide_data,
            sop:   buf_pkt[s].sop,
            eop:   buf_pkt[s].eop
        };
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Reset lifts on a falling edge, well away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
